/* common/fb_config.svh */
`ifndef FB_CONFIG_SVH
`define FB_CONFIG_SVH

`define FB_NUM_CH        2      // write channels sharing the ddr port
`define FB_PIX_W         16     // rgb565 pixel
`define FB_DQ_W          256    // ddr word, 16 pixels
`define FB_PIX_PER_WORD  16
`define FB_ADDR_W        28     // byte address
`define FB_BURST_WORDS   4      // words per AXI burst
`define FB_WORD_BYTES    32
`define FB_FIFO_DEPTH    8      // two bursts per channel
`define FB_SIZE_W        12     // h_num / v_num width

`endif

/* common/fb_pkg.sv */
`include "fb_config.svh"

package fb_pkg;

    typedef logic [`FB_PIX_W-1:0]            pix_t;
    typedef logic [`FB_DQ_W-1:0]             ddr_word_t;
    typedef logic [`FB_ADDR_W-1:0]           ddr_addr_t;
    typedef logic [`FB_SIZE_W-1:0]           frame_size_t;
    typedef logic [$clog2(`FB_NUM_CH)-1:0]   ch_idx_t;     // also the AXI id

    // AXI write master states
    typedef enum logic [1:0]
    {
        WR_IDLE,    // wait for a command
        WR_ADDR,    // awvalid up
        WR_DATA,    // beat run
        WR_DONE     // cmd_done pulse
    } axi_wr_state_t;

endpackage

/* wr_buf/word_fifo.sv */
`timescale 1ns/1ps
`include "fb_config.svh"

module word_fifo
(
    input  logic                                  ddr_clk,
    input  logic                                  rst_n,
    input  logic                                  push,
    input  logic [`FB_DQ_W-1:0]                   push_data,
    input  logic                                  pop,
    output logic [`FB_DQ_W-1:0]                   head,       // show-ahead
    output logic [$clog2(`FB_FIFO_DEPTH+1)-1:0]   count
);
    localparam int PTR_W = $clog2(`FB_FIFO_DEPTH);

    logic [`FB_DQ_W-1:0] mem [`FB_FIFO_DEPTH];
    logic [PTR_W-1:0]    wr_ptr;
    logic [PTR_W-1:0]    rd_ptr;

    always_ff @(posedge ddr_clk)
    begin
        if (push)
            mem[wr_ptr] <= push_data;
    end

    always_ff @(posedge ddr_clk)
    begin
        if (!rst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= (wr_ptr == PTR_W'(`FB_FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == PTR_W'(`FB_FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;        // both or neither
            endcase
        end
    end

    assign head = mem[rd_ptr];                  // valid whenever count != 0

    // video side has no back-pressure, master pops only what wr_req announced
    assert property (@(posedge ddr_clk) disable iff (!rst_n)
        !(push && count == `FB_FIFO_DEPTH) && !(pop && count == 0))
        else $error("word_fifo overflow or underflow");

endmodule

/* wr_buf/wr_buf.sv */
`timescale 1ns/1ps
`include "fb_config.svh"

module wr_buf
(
    input  logic                ddr_clk,
    input  logic                rst_n,
    input  fb_pkg::ddr_addr_t   addr_offset,    // frame base in ddr
    input  fb_pkg::frame_size_t h_num,          // pixels per line
    input  fb_pkg::frame_size_t v_num,          // lines per frame
    input  logic                wr_fsync,
    input  logic                wr_en,
    input  fb_pkg::pix_t        wr_data,
    output logic                wr_req,
    output fb_pkg::ddr_addr_t   wr_addr,
    input  logic                wr_rdy,
    input  logic                wdata_req,
    output fb_pkg::ddr_word_t   ddr_wdata,
    input  logic                wr_done,
    output logic                init_done
);
    import fb_pkg::*;

    localparam int CNT_W    = $clog2(`FB_FIFO_DEPTH + 1);
    localparam int PCNT_W   = $clog2(`FB_PIX_PER_WORD);
    localparam int BPIX_SH  = $clog2(`FB_BURST_WORDS * `FB_PIX_PER_WORD);   // 64 pixels
    localparam int BBYTE_SH = $clog2(`FB_BURST_WORDS * `FB_WORD_BYTES);     // 128 bytes
    localparam int FPIX_W   = 2 * `FB_SIZE_W;
    localparam int BIDX_W   = FPIX_W - BPIX_SH;

    logic [PCNT_W-1:0] pix_cnt;         // pixels already in pack_q
    ddr_word_t         pack_q;
    ddr_word_t         pack_nxt;
    logic              word_push;
    logic [CNT_W-1:0]  fifo_cnt;
    logic              busy;            // command accepted, burst not done
    logic [BIDX_W-1:0] burst_idx;       // bursts sent in this frame
    logic [BIDX_W-1:0] last_bidx;
    logic [FPIX_W-1:0] frame_pix;

    // new pixel enters at the top, first pixel ends up in the low bits
    assign pack_nxt  = {wr_data, pack_q[`FB_DQ_W-1:`FB_PIX_W]};
    assign word_push = wr_en && !wr_fsync && (pix_cnt == PCNT_W'(`FB_PIX_PER_WORD - 1));

    always_ff @(posedge ddr_clk)
    begin
        if (wr_en)
            pack_q <= pack_nxt;
    end

    always_ff @(posedge ddr_clk)
    begin
        if (!rst_n)
            pix_cnt <= '0;
        else if (wr_fsync)
            pix_cnt <= '0;                  // realign to frame start
        else if (wr_en)
            pix_cnt <= word_push ? '0 : pix_cnt + 1'b1;
    end

    word_fifo u_word_fifo
    (
        .ddr_clk   (ddr_clk),
        .rst_n     (rst_n),
        .push      (word_push),
        .push_data (pack_nxt),              // sixteenth pixel goes in same cycle
        .pop       (wdata_req),
        .head      (ddr_wdata),
        .count     (fifo_cnt)
    );

    assign wr_req = (fifo_cnt >= CNT_W'(`FB_BURST_WORDS)) && !busy;

    always_ff @(posedge ddr_clk)
    begin
        if (!rst_n)
            busy <= 1'b0;
        else if (wr_rdy)
            busy <= 1'b1;
        else if (wr_done)
            busy <= 1'b0;
    end

    assign frame_pix = FPIX_W'(h_num) * FPIX_W'(v_num);
    assign last_bidx = frame_pix[FPIX_W-1:BPIX_SH] - 1'b1;     // needs multiple of 64
    assign wr_addr   = addr_offset + (ddr_addr_t'(burst_idx) << BBYTE_SH);

    always_ff @(posedge ddr_clk)
    begin
        if (!rst_n)
        begin
            burst_idx <= '0;
            init_done <= 1'b0;
        end
        else
        begin
            if (wr_fsync)
                burst_idx <= '0;
            else if (wr_done)
                burst_idx <= burst_idx + 1'b1;
            if (wr_done && burst_idx == last_bidx)
                init_done <= 1'b1;          // sticky, first full frame in ddr
        end
    end

endmodule

/* source/ddr_arbit.sv */
`timescale 1ns/1ps
`include "fb_config.svh"

module ddr_arbit
(
    input  logic                                ddr_clk,
    input  logic                                rst_n,
    input  logic [`FB_NUM_CH-1:0]               wr_req,
    input  fb_pkg::ddr_addr_t [`FB_NUM_CH-1:0]  wr_addr,
    input  fb_pkg::ddr_word_t [`FB_NUM_CH-1:0]  wr_data,
    output logic [`FB_NUM_CH-1:0]               wr_rdy,
    output logic [`FB_NUM_CH-1:0]               wdata_req,
    output logic [`FB_NUM_CH-1:0]               wr_done,
    output logic                                cmd_en,
    output fb_pkg::ddr_addr_t                   cmd_addr,
    output fb_pkg::ch_idx_t                     cmd_id,
    output fb_pkg::ddr_word_t                   ctrl_data,
    input  logic                                cmd_ready,
    input  logic                                cmd_done,
    input  logic                                data_re
);
    import fb_pkg::*;

    localparam int NCH = `FB_NUM_CH;

    logic           grant_vld;
    ch_idx_t        grant_id;           // kept after release, last winner
    logic [NCH-1:0] grant_oh;
    logic           pick_vld;
    ch_idx_t        pick_id;

    // search starts one past the last winner
    always_comb
    begin
        int idx;
        pick_vld = 1'b0;
        pick_id  = grant_id;
        for (int k = 1; k <= NCH; k++)
        begin
            idx = (int'(grant_id) + k) % NCH;
            if (!pick_vld && wr_req[idx])
            begin
                pick_vld = 1'b1;
                pick_id  = ch_idx_t'(idx);
            end
        end
    end

    always_ff @(posedge ddr_clk)
    begin
        if (!rst_n)
        begin
            grant_vld <= 1'b0;
            grant_id  <= ch_idx_t'(NCH - 1);    // channel 0 wins first
            cmd_en    <= 1'b0;
        end
        else if (!grant_vld)
        begin
            if (pick_vld)
            begin
                grant_vld <= 1'b1;
                grant_id  <= pick_id;
                cmd_en    <= 1'b1;
            end
        end
        else
        begin
            if (cmd_ready)
                cmd_en <= 1'b0;
            if (cmd_done)
                grant_vld <= 1'b0;          // free again next cycle
        end
    end

    assign grant_oh  = grant_vld ? (NCH'(1) << grant_id) : '0;
    assign wr_rdy    = cmd_ready ? grant_oh : '0;
    assign wdata_req = data_re   ? grant_oh : '0;
    assign wr_done   = cmd_done  ? grant_oh : '0;

    assign cmd_addr  = wr_addr[grant_id];
    assign cmd_id    = grant_id;
    assign ctrl_data = wr_data[grant_id];   // show-ahead head of winner

    // master handshakes only ever land on exactly one granted channel
    assert property (@(posedge ddr_clk) disable iff (!rst_n)
        (cmd_ready || data_re || cmd_done) |-> $onehot(grant_oh))
        else $error("ddr_arbit handshake without single grant");

endmodule

/* source/axi_wr_ctrl.sv */
`timescale 1ns/1ps
`include "fb_config.svh"

module axi_wr_ctrl
(
    input  logic                     ddr_clk,
    input  logic                     rst_n,
    input  logic                     cmd_en,
    input  fb_pkg::ddr_addr_t        cmd_addr,
    input  fb_pkg::ch_idx_t          cmd_id,
    output logic                     cmd_ready,
    output logic                     cmd_done,
    input  fb_pkg::ddr_word_t        ctrl_data,
    output logic                     data_re,
    output fb_pkg::ddr_addr_t        axi_awaddr,
    output logic [3:0]               axi_awid,
    output logic [3:0]               axi_awlen,
    output logic [2:0]               axi_awsize,
    output logic [1:0]               axi_awburst,
    input  logic                     axi_awready,
    output logic                     axi_awvalid,
    output fb_pkg::ddr_word_t        axi_wdata,
    output logic [`FB_DQ_W/8-1:0]    axi_wstrb,
    output logic                     axi_wlast,
    output logic                     axi_wvalid,
    input  logic                     axi_wready
);
    import fb_pkg::*;

    localparam int BEAT_W = $clog2(`FB_BURST_WORDS);

    axi_wr_state_t     state;
    axi_wr_state_t     state_nxt;
    logic [BEAT_W-1:0] beat_cnt;
    ch_idx_t           awid_q;

    always_comb
    begin
        state_nxt = state;
        case (state)
            WR_IDLE: if (cmd_en) state_nxt = WR_ADDR;
            WR_ADDR: if (axi_awready) state_nxt = WR_DATA;
            WR_DATA: if (axi_wready && axi_wlast) state_nxt = WR_DONE;
            default: state_nxt = WR_IDLE;       // done lasts one cycle
        endcase
    end

    always_ff @(posedge ddr_clk)
    begin
        if (!rst_n)
        begin
            state    <= WR_IDLE;
            beat_cnt <= '0;
        end
        else
        begin
            state <= state_nxt;
            if (state == WR_ADDR)
                beat_cnt <= '0;
            else if (data_re)
                beat_cnt <= beat_cnt + 1'b1;
        end
    end

    // latch the command on accept
    always_ff @(posedge ddr_clk)
    begin
        if (cmd_ready)
        begin
            axi_awaddr <= cmd_addr;
            awid_q     <= cmd_id;
        end
    end

    assign cmd_ready   = (state == WR_IDLE) && cmd_en;
    assign cmd_done    = (state == WR_DONE);
    assign axi_awvalid = (state == WR_ADDR);
    assign axi_awid    = 4'(awid_q);
    assign axi_awlen   = 4'(`FB_BURST_WORDS - 1);
    assign axi_awsize  = 3'($clog2(`FB_WORD_BYTES));  // 32 bytes per beat
    assign axi_awburst = 2'b01;                         // INCR
    assign axi_wstrb   = '1;

    assign axi_wvalid  = (state == WR_DATA);
    assign axi_wlast   = axi_wvalid && (beat_cnt == BEAT_W'(`FB_BURST_WORDS - 1));
    assign axi_wdata   = ctrl_data;                     // fifo head held until pop
    assign data_re     = axi_wvalid && axi_wready;

    // beat data comes from the fifo head and must hold through a wready stall
    assert property (@(posedge ddr_clk) disable iff (!rst_n)
        axi_wvalid && !axi_wready |=> axi_wvalid && $stable(axi_wdata))
        else $error("wdata changed while wvalid stalled");

endmodule

/* source/frame_buf.sv */
`timescale 1ns/1ps
`include "fb_config.svh"

module frame_buf
(
    input  logic                                  ddr_clk,
    input  logic                                  rst_n,
    input  fb_pkg::ddr_addr_t   [`FB_NUM_CH-1:0]  addr_offset,
    input  fb_pkg::frame_size_t [`FB_NUM_CH-1:0]  h_num,
    input  fb_pkg::frame_size_t [`FB_NUM_CH-1:0]  v_num,
    input  logic [`FB_NUM_CH-1:0]                 wr_fsync,
    input  logic [`FB_NUM_CH-1:0]                 wr_en,
    input  fb_pkg::pix_t        [`FB_NUM_CH-1:0]  wr_data,
    output logic [`FB_NUM_CH-1:0]                 init_done,
    output fb_pkg::ddr_addr_t                     axi_awaddr,
    output logic [3:0]                            axi_awid,
    output logic [3:0]                            axi_awlen,
    output logic [2:0]                            axi_awsize,
    output logic [1:0]                            axi_awburst,
    input  logic                                  axi_awready,
    output logic                                  axi_awvalid,
    output fb_pkg::ddr_word_t                     axi_wdata,
    output logic [`FB_DQ_W/8-1:0]                 axi_wstrb,
    output logic                                  axi_wlast,
    output logic                                  axi_wvalid,
    input  logic                                  axi_wready
);
    import fb_pkg::*;

    logic      [`FB_NUM_CH-1:0] wr_req;
    ddr_addr_t [`FB_NUM_CH-1:0] wr_addr;
    ddr_word_t [`FB_NUM_CH-1:0] ch_wdata;       // fifo heads
    logic      [`FB_NUM_CH-1:0] wr_rdy;
    logic      [`FB_NUM_CH-1:0] wdata_req;
    logic      [`FB_NUM_CH-1:0] wr_done;

    logic      cmd_en;
    ddr_addr_t cmd_addr;
    ch_idx_t   cmd_id;
    logic      cmd_ready;
    logic      cmd_done;
    ddr_word_t ctrl_data;
    logic      data_re;

    for (genvar i = 0; i < `FB_NUM_CH; i++)
    begin : g_ch
        wr_buf u_wr_buf
        (
            .ddr_clk     (ddr_clk),
            .rst_n       (rst_n),
            .addr_offset (addr_offset[i]),
            .h_num       (h_num[i]),
            .v_num       (v_num[i]),
            .wr_fsync    (wr_fsync[i]),
            .wr_en       (wr_en[i]),
            .wr_data     (wr_data[i]),
            .wr_req      (wr_req[i]),
            .wr_addr     (wr_addr[i]),
            .wr_rdy      (wr_rdy[i]),
            .wdata_req   (wdata_req[i]),
            .ddr_wdata   (ch_wdata[i]),
            .wr_done     (wr_done[i]),
            .init_done   (init_done[i])
        );
    end

    ddr_arbit u_ddr_arbit
    (
        .ddr_clk   (ddr_clk),
        .rst_n     (rst_n),
        .wr_req    (wr_req),
        .wr_addr   (wr_addr),
        .wr_data   (ch_wdata),
        .wr_rdy    (wr_rdy),
        .wdata_req (wdata_req),
        .wr_done   (wr_done),
        .cmd_en    (cmd_en),
        .cmd_addr  (cmd_addr),
        .cmd_id    (cmd_id),
        .ctrl_data (ctrl_data),
        .cmd_ready (cmd_ready),
        .cmd_done  (cmd_done),
        .data_re   (data_re)
    );

    axi_wr_ctrl u_axi_wr_ctrl
    (
        .ddr_clk     (ddr_clk),
        .rst_n       (rst_n),
        .cmd_en      (cmd_en),
        .cmd_addr    (cmd_addr),
        .cmd_id      (cmd_id),
        .cmd_ready   (cmd_ready),
        .cmd_done    (cmd_done),
        .ctrl_data   (ctrl_data),
        .data_re     (data_re),
        .axi_awaddr  (axi_awaddr),
        .axi_awid    (axi_awid),
        .axi_awlen   (axi_awlen),
        .axi_awsize  (axi_awsize),
        .axi_awburst (axi_awburst),
        .axi_awready (axi_awready),
        .axi_awvalid (axi_awvalid),
        .axi_wdata   (axi_wdata),
        .axi_wstrb   (axi_wstrb),
        .axi_wlast   (axi_wlast),
        .axi_wvalid  (axi_wvalid),
        .axi_wready  (axi_wready)
    );

endmodule

/* sim/tb_frame_buf.sv */
`timescale 1ns/1ps
`include "fb_config.svh"

module tb_frame_buf;

    localparam int NCH         = `FB_NUM_CH;
    localparam int PIX_W       = `FB_PIX_W;
    localparam int PPW         = `FB_PIX_PER_WORD;
    localparam int BURST_PIX   = `FB_BURST_WORDS * `FB_PIX_PER_WORD;    // 64 pixels
    localparam int BURST_BYTES = `FB_BURST_WORDS * `FB_WORD_BYTES;      // 128 bytes
    localparam int MAX_TESTS   = 32;

    logic                           ddr_clk = 1'b0;
    logic                           rst_n = 1'b0;
    logic [NCH-1:0][`FB_ADDR_W-1:0] addr_offset;
    logic [NCH-1:0][`FB_SIZE_W-1:0] h_num;
    logic [NCH-1:0][`FB_SIZE_W-1:0] v_num;
    logic [NCH-1:0]                 wr_fsync;
    logic [NCH-1:0]                 wr_en;
    logic [NCH-1:0][PIX_W-1:0]      wr_data;
    logic [NCH-1:0]                 init_done;
    logic [`FB_ADDR_W-1:0]          axi_awaddr;
    logic [3:0]                     axi_awid;
    logic [3:0]                     axi_awlen;
    logic [2:0]                     axi_awsize;
    logic [1:0]                     axi_awburst;
    logic                           axi_awready = 1'b0;
    logic                           axi_awvalid;
    logic [`FB_DQ_W-1:0]            axi_wdata;
    logic [`FB_DQ_W/8-1:0]          axi_wstrb;
    logic                           axi_wlast;
    logic                           axi_wvalid;
    logic                           axi_wready = 1'b0;

    // one entry per stim line
    int                    t_mask   [MAX_TESTS];
    int                    t_h      [MAX_TESTS];
    int                    t_v      [MAX_TESTS];
    logic [`FB_ADDR_W-1:0] t_off    [MAX_TESTS][NCH];
    logic [31:0]           t_seed   [MAX_TESTS];
    int                    t_aw     [MAX_TESTS];
    int                    t_w      [MAX_TESTS];
    int                    t_frames [MAX_TESTS];
    int                    n_tests = 0;

    logic [`FB_ADDR_W-1:0] exp_addr [NCH][$];      // per channel AW order
    logic [`FB_DQ_W-1:0]   exp_word [NCH][$];      // per channel W order
    int                    bursts_done [NCH];
    int                    pix_sent [NCH];          // pixels driven since reset
    logic [NCH-1:0]        init_seen = '0;
    logic [NCH-1:0]        cur_mask = '0;
    int                    bpf = 1;                 // bursts per frame
    int                    w_ch = 0;                // owner of the burst in flight
    int                    w_beat = 0;
    int                    last_aw_id = -1;
    int                    aw_stall = 0;
    int                    w_stall = 0;
    logic [31:0]           pix_rng = 32'd46;
    logic [31:0]           stall_rng = 32'd46;
    int                    flow_err = 0;
    int                    mon_err = 0;
    int                    aw_total = 0;
    longint                cycle_cnt = 0;
    longint                cycle_limit = 1000000000;   // set once the stim is read

    frame_buf UUT
    (
        .ddr_clk     (ddr_clk),
        .rst_n       (rst_n),
        .addr_offset (addr_offset),
        .h_num       (h_num),
        .v_num       (v_num),
        .wr_fsync    (wr_fsync),
        .wr_en       (wr_en),
        .wr_data     (wr_data),
        .init_done   (init_done),
        .axi_awaddr  (axi_awaddr),
        .axi_awid    (axi_awid),
        .axi_awlen   (axi_awlen),
        .axi_awsize  (axi_awsize),
        .axi_awburst (axi_awburst),
        .axi_awready (axi_awready),
        .axi_awvalid (axi_awvalid),
        .axi_wdata   (axi_wdata),
        .axi_wstrb   (axi_wstrb),
        .axi_wlast   (axi_wlast),
        .axi_wvalid  (axi_wvalid),
        .axi_wready  (axi_wready)
    );

    always #20 ddr_clk = ~ddr_clk;                  // 40 ns period

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    always @(posedge ddr_clk)
    begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > cycle_limit)
        begin
            $display("timeout after %0d cycles, bursts were still outstanding", cycle_cnt);
            $display("TEST FAILED");
            $finish;
        end
    end

    // AXI slave ready lines with random stalls
    always @(posedge ddr_clk)
    begin
        #2;
        stall_rng   = xorshift(stall_rng);
        axi_awready = int'(stall_rng % 100) >= aw_stall;
        stall_rng   = xorshift(stall_rng);
        axi_wready  = int'(stall_rng % 100) >= w_stall;
    end

    task automatic check_quiet_start();
        logic burst_driven;
        burst_driven = 1'b0;
        for (int c = 0; c < NCH; c++)
            if (pix_sent[c] >= BURST_PIX)
                burst_driven = 1'b1;
        if ((axi_awvalid || axi_wvalid) && !burst_driven)
        begin
            $display("Error %0t: AXI write active before any burst was queued", $time);
            mon_err++;
        end
    endtask

    task automatic check_aw();
        int                    id;
        logic [`FB_ADDR_W-1:0] want;
        id = int'(axi_awid);
        aw_total++;
        if (axi_awlen != 4'(`FB_BURST_WORDS - 1) || axi_awsize != 3'd5 || axi_awburst != 2'b01)
        begin
            $display("Error %0t: AW len %0d size %0d burst %0d, expected %0d 5 1", $time,
                     axi_awlen, axi_awsize, axi_awburst, `FB_BURST_WORDS - 1);
            mon_err++;
        end
        if (id >= NCH || !cur_mask[id])
        begin
            $display("Error %0t: AW with id %0d from an idle channel", $time, id);
            mon_err++;
            id = 0;
        end
        else if (exp_addr[id].size() == 0)
        begin
            $display("Error %0t: AW on ch%0d beyond the end of the frame", $time, id);
            mon_err++;
        end
        else
        begin
            want = exp_addr[id].pop_front();
            if (axi_awaddr != want)
            begin
                $display("Error %0t: ch%0d awaddr %h, expected %h", $time, id, axi_awaddr, want);
                mon_err++;
            end
        end
        if (cur_mask == '1 && last_aw_id == id)     // both busy so grants must alternate
        begin
            $display("Error %0t: ch%0d granted twice in a row", $time, id);
            mon_err++;
        end
        last_aw_id = id;
        w_ch       = id;
        w_beat     = 0;
    endtask

    task automatic check_beat();
        logic [`FB_DQ_W-1:0] want;
        if (w_beat >= `FB_BURST_WORDS)
        begin
            $display("Error %0t: W beat on ch%0d outside an open burst", $time, w_ch);
            mon_err++;
        end
        if (axi_wstrb != '1)
        begin
            $display("Error %0t: wstrb %h, expected all ones", $time, axi_wstrb);
            mon_err++;
        end
        if (exp_word[w_ch].size() == 0)
        begin
            $display("Error %0t: W beat on ch%0d with no word queued", $time, w_ch);
            mon_err++;
        end
        else
        begin
            want = exp_word[w_ch].pop_front();
            if (axi_wdata != want)
            begin
                $display("Error %0t: ch%0d beat %0d data %h, expected %h", $time, w_ch, w_beat,
                         axi_wdata, want);
                mon_err++;
            end
        end
        if (axi_wlast != (w_beat == `FB_BURST_WORDS - 1))
        begin
            $display("Error %0t: wlast %0b on beat %0d", $time, axi_wlast, w_beat);
            mon_err++;
        end
        if (w_beat == `FB_BURST_WORDS - 1)
            bursts_done[w_ch]++;
        w_beat++;
    endtask

    task automatic check_init_done();
        for (int c = 0; c < NCH; c++)
        begin
            if (init_done[c] && bursts_done[c] < bpf)
            begin
                $display("Error %0t: ch%0d init_done after %0d of %0d bursts", $time, c,
                         bursts_done[c], bpf);
                mon_err++;
            end
            if (init_seen[c] && !init_done[c])
            begin
                $display("Error %0t: ch%0d init_done dropped", $time, c);
                mon_err++;
            end
            init_seen[c] = init_seen[c] | init_done[c];
        end
    endtask

    // outputs settled mid-cycle and handshakes complete on the next edge
    always @(negedge ddr_clk)
    begin
        if (!rst_n)
        begin
            for (int c = 0; c < NCH; c++)
                bursts_done[c] = 0;
            init_seen  = '0;
            last_aw_id = -1;
            w_beat     = `FB_BURST_WORDS;
        end
        else
        begin
            check_quiet_start();
            if (axi_awvalid && axi_awready)
                check_aw();
            if (axi_wvalid && axi_wready)
                check_beat();
            check_init_done();
        end
    end

    task automatic read_stim();
        int          fd;
        int          n;
        string       line;
        int          mask;
        int          h;
        int          v;
        int          aws;
        int          ws;
        int          fr;
        logic [31:0] o0;
        logic [31:0] o1;
        logic [31:0] seed;
        fd = $fopen("sim/frame_buf_stim.txt", "r");
        if (fd == 0)
        begin
            $display("could not open sim/frame_buf_stim.txt");
            flow_err++;
            return;
        end
        while (!$feof(fd) && n_tests < MAX_TESTS)
        begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 0 && line.getc(0) != "#")
            begin
                n = $sscanf(line, "%d %d %d %h %h %h %d %d %d", mask, h, v, o0, o1, seed,
                            aws, ws, fr);
                if (n == 9)
                begin
                    t_mask[n_tests]   = mask;
                    t_h[n_tests]      = h;
                    t_v[n_tests]      = v;
                    t_off[n_tests][0] = o0[`FB_ADDR_W-1:0];
                    t_off[n_tests][1] = o1[`FB_ADDR_W-1:0];
                    t_seed[n_tests]   = seed;
                    t_aw[n_tests]     = aws;
                    t_w[n_tests]      = ws;
                    t_frames[n_tests] = fr;
                    n_tests++;
                end
            end
        end
        $fclose(fd);
        if (n_tests == 0)
        begin
            $display("no test lines found in sim/frame_buf_stim.txt");
            flow_err++;
        end
    endtask

    // one pixel every other cycle with all active channels in lockstep
    task automatic send_frame(input int t);
        logic [`FB_DQ_W-1:0]   word_acc [NCH];
        logic [`FB_ADDR_W-1:0] step;
        int                    npix;
        int                    slot;
        npix     = t_h[t] * t_v[t];
        wr_fsync = cur_mask;                        // restart packer and burst index
        @(posedge ddr_clk);
        #2;
        wr_fsync = '0;
        for (int p = 0; p < npix; p++)
        begin
            slot = p % PPW;
            step = `FB_ADDR_W'((p / BURST_PIX) * BURST_BYTES);
            for (int c = 0; c < NCH; c++)
            begin
                if (cur_mask[c])
                begin
                    pix_rng    = xorshift(pix_rng);
                    wr_data[c] = pix_rng[PIX_W-1:0];
                    word_acc[c][PIX_W*slot +: PIX_W] = pix_rng[PIX_W-1:0];  // first pixel lowest
                    if (slot == PPW - 1)
                        exp_word[c].push_back(word_acc[c]);
                    if (p % BURST_PIX == BURST_PIX - 1)
                        exp_addr[c].push_back(t_off[t][c] + step);
                    pix_sent[c]++;
                end
            end
            wr_en = cur_mask;
            @(posedge ddr_clk);
            #2;
            wr_en = '0;
            @(posedge ddr_clk);
            #2;
        end
    endtask

    // until every queued burst has gone out on AXI
    task automatic wait_drain();
        logic pending;
        pending = 1'b1;
        while (pending)
        begin
            pending = 1'b0;
            for (int c = 0; c < NCH; c++)
                if (exp_word[c].size() != 0 || exp_addr[c].size() != 0)
                    pending = 1'b1;
            if (pending)
                @(posedge ddr_clk);
        end
        repeat (3) @(posedge ddr_clk);              // let wr_done reach the channel
        #2;
    endtask

    task automatic run_test(input int t);
        int errs_before;
        int bursts;
        errs_before = flow_err + mon_err;
        @(posedge ddr_clk);
        #2;
        rst_n    = 1'b0;
        cur_mask = t_mask[t][NCH-1:0];
        bpf      = t_h[t] * t_v[t] / BURST_PIX;
        aw_stall = t_aw[t];
        w_stall  = t_w[t];
        pix_rng  = t_seed[t];                       // pixel stream per line
        for (int c = 0; c < NCH; c++)
        begin
            addr_offset[c] = t_off[t][c];
            h_num[c]       = t_h[t][`FB_SIZE_W-1:0];
            v_num[c]       = t_v[t][`FB_SIZE_W-1:0];
            pix_sent[c]    = 0;
        end
        repeat (8) @(posedge ddr_clk);
        #2;
        rst_n = 1'b1;
        if (axi_awvalid || axi_wvalid || init_done != '0)
        begin
            $display("Error %0t: AXI valid or init_done high right after reset", $time);
            flow_err++;
        end
        for (int f = 0; f < t_frames[t]; f++)
        begin
            send_frame(t);
            wait_drain();
        end
        bursts = 0;
        for (int c = 0; c < NCH; c++)
        begin
            bursts += bursts_done[c];
            if (init_done[c] != cur_mask[c])
            begin
                $display("Error %0t: ch%0d init_done %0b at end, expected %0b", $time, c,
                         init_done[c], cur_mask[c]);
                flow_err++;
            end
            if (cur_mask[c] && bursts_done[c] != bpf * t_frames[t])
            begin
                $display("Error %0t: ch%0d wrote %0d bursts, expected %0d", $time, c,
                         bursts_done[c], bpf * t_frames[t]);
                flow_err++;
            end
        end
        $display("test %0d: mask %0d, %0dx%0d, %0d frame(s), %0d bursts, %s", t, t_mask[t],
                 t_h[t], t_v[t], t_frames[t], bursts,
                 (flow_err + mon_err == errs_before) ? "passed" : "failed");
    endtask

    initial
    begin
        longint total_pix;
        addr_offset = '0;
        h_num       = '0;
        v_num       = '0;
        wr_fsync    = '0;
        wr_en       = '0;
        wr_data     = '0;
        read_stim();
        total_pix = 0;
        for (int t = 0; t < n_tests; t++)
            total_pix += longint'(t_h[t] * t_v[t] * t_frames[t] *
                                  $countones(t_mask[t][NCH-1:0]));
        cycle_limit = total_pix * 4 + 1000;
        for (int t = 0; t < n_tests; t++)
            run_test(t);
        $display("%0d tests, %0d bursts checked, %0d errors", n_tests, aw_total,
                 flow_err + mon_err);
        if (flow_err + mon_err == 0 && n_tests > 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

/* sim/frame_buf_stim.txt */
# mask h_num v_num offset0 offset1 seed awready_stall% wready_stall% frames
# mask bit n enables channel n, offsets and seed are hex, the rest decimal
# h_num * v_num is a multiple of 64 pixels
# single channel addressing and packing, no stalls
1 64 2 0100000 0000000 0000a3c1 0 0 1
2 32 4 0000000 0200040 00712f0b 0 0 1
# both channels, round robin
3 64 4 0100000 0800000 12345678 0 0 1
3 64 2 0000400 0a00000 0badf00d 70 0 1
# random awready and wready stalls
1 128 2 0300080 0000000 5eed0001 30 40 1
2 64 3 0000000 0400000 00c0ffee 40 50 1
3 64 4 0120000 0940000 76543210 40 50 1
# several frames, addresses restart on fsync
3 64 2 0010000 0020000 13572468 20 20 3
2 128 1 0000000 0f00000 00000bad 50 50 2
3 256 1 0200000 0600000 2468ace0 60 30 2
1 64 1 0ffff00 0000000 0000002e 10 10 4

/* verilog.f */
+incdir+common
common/fb_pkg.sv
wr_buf/word_fifo.sv
wr_buf/wr_buf.sv
source/ddr_arbit.sv
source/axi_wr_ctrl.sv
source/frame_buf.sv
sim/tb_frame_buf.sv

/* Makefile */
SIM    = verilator
FLAGS  = --binary --timing --assert -j 0
TOP    = tb_frame_buf
FLIST  = verilog.f
OBJDIR = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJDIR)

# pass only if the simulation printed the pass line
run: compile
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "TEST OK"

clean:
	rm -rf $(OBJDIR)
